//--- ddr_macros.svh
`ifndef DDR_MACROS_SVH
`define DDR_MACROS_SVH

// scl stall lengths, counted in scl cycles
`define DDR_RESTART_STALL 5'd10 // ahead of the restart pattern
`define DDR_EXIT_STALL    5'd16 // ahead of the exit pattern

// 7-bit target address = base + device index
`define DDR_ADDR_BASE 7'd8

// bit counts inside the crc value where the stall request goes out
`define DDR_STALL_BIT_LO 6'd11
`define DDR_STALL_BIT_HI 6'd12

// register file
`define DDR_REGF_AW   12
`define DDR_IMM_ADDR  12'd20   // first immediate data byte
`define DDR_WR_ADDR   12'd1    // first byte of a regular write
`define DDR_RD_ADDR   12'd10   // first byte of a regular read
`define DDR_LAST_ADDR 12'd1000 // parked here once the last byte is done

`endif

//--- ddr_proto_pkg.sv
`default_nettype none

package ddr_proto_pkg;

	// one hdr-ddr frame, command word through restart/exit
	typedef enum logic [4:0] {
		st_idle         = 5'd0,
		st_cmd_pre      = 5'd1,  // command preamble
		st_seven_zeros  = 5'd2,
		st_address      = 5'd3,
		st_parity       = 5'd4,  // command or data parity
		st_ack_pre      = 5'd5,  // controller preamble ahead of the ack
		st_ack_wait     = 5'd6,
		st_first_byte   = 5'd7,
		st_second_byte  = 5'd8,
		st_data_pre     = 5'd9,  // preamble after a data word
		st_abort_bit    = 5'd10,
		st_crc_pre1     = 5'd11,
		st_crc_pre2     = 5'd12,
		st_token        = 5'd13,
		st_crc_value    = 5'd14,
		st_error        = 5'd15,
		st_restart      = 5'd16,
		st_exit         = 5'd17,
		st_rnw_bit      = 5'd18,
		st_zero_pad     = 5'd19  // dummy byte for an odd byte count
	} frame_state_t;

	// serializer modes
	typedef enum logic [3:0] {
		tx_seven_zeros = 4'd0,
		tx_address     = 4'd1,
		tx_special_pre = 4'd2, // 01 preamble
		tx_one_pre     = 4'd3,
		tx_zero_pre    = 4'd4,
		tx_byte        = 4'd5,
		tx_parity      = 4'd6,
		tx_crc_value   = 4'd7,
		tx_token_crc   = 4'd8,
		tx_restart     = 4'd9,
		tx_exit        = 4'd10
	} tx_mode_t;

	// deserializer modes, gaps are codes the phy no longer uses
	typedef enum logic [3:0] {
		rx_preamble = 4'd0,
		rx_byte     = 4'd3,
		rx_token    = 4'd4,
		rx_parity   = 4'd5,
		rx_crc      = 4'd6,
		rx_error    = 4'd7  // wait out the bus after a failure
	} rx_mode_t;

	// codes reported to the register file
	typedef enum logic [3:0] {
		err_success     = 4'd0,
		err_crc         = 4'd1,
		err_parity      = 4'd2,
		err_frame       = 4'd3,
		err_nack        = 4'd5,
		err_short_read  = 4'd7,
		err_bus_aborted = 4'd9
	} err_type_t;

	typedef struct packed {
		frame_state_t state;
		logic         ack_ready;   // ack wait has run one cycle
		logic         data_parity; // next parity belongs to data
	} engine_status_t;

endpackage

`default_nettype wire

//--- ddr_regf_pkg.sv
`default_nettype none

`include "ddr_macros.svh"

package ddr_regf_pkg;

	// transfer settings, held stable by the register file for a whole frame
	typedef struct packed {
		logic       toc;        // 0 restart, 1 exit
		logic [4:0] dev_index;
		logic       short_read; // 1 makes a short read an error
		logic       rnw;        // 0 write, 1 read
		logic [2:0] cmd_attr;   // bit 0 set for immediate transfer
		logic [2:0] dtt;        // data byte count
	} xfer_req_t;

	// register file access
	typedef struct packed {
		logic                    wr_en;
		logic                    rd_en;
		logic [`DDR_REGF_AW-1:0] addr;
	} regf_port_t;

endpackage

`default_nettype wire

//--- ddr_frame_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module ddr_frame_fsm (
	input  wire                           i_sys_clk,
	input  wire                           i_sys_rst,
	input  wire                           i_engine_en,
	input  wire                           i_tx_mode_done,
	input  wire                           i_rx_mode_done,
	input  wire                           i_rx_pre,
	input  wire                           i_rx_error,
	input  wire                           i_frmcnt_last,
	input  wire ddr_regf_pkg::xfer_req_t  i_xfer,
	output ddr_proto_pkg::engine_status_t o_status,
	output ddr_proto_pkg::err_type_t      o_regf_error_type,
	output logic                          o_regf_abort
);

	ddr_proto_pkg::frame_state_t state_q;
	ddr_proto_pkg::frame_state_t state_d;
	logic ack_ready_q;
	logic data_parity_q;
	logic any_done; // each state moves on its own done pulse
	logic rnw;
	ddr_proto_pkg::frame_state_t close_st; // restart or exit per toc

	assign any_done = i_tx_mode_done | i_rx_mode_done;
	assign rnw      = i_xfer.rnw;
	assign close_st = i_xfer.toc ? ddr_proto_pkg::st_exit : ddr_proto_pkg::st_restart;

	always_comb
	begin
		state_d = state_q; // hold until the awaited pulse
		case (state_q)
			ddr_proto_pkg::st_idle:
				if (i_engine_en)
					state_d = ddr_proto_pkg::st_cmd_pre;
			ddr_proto_pkg::st_cmd_pre:
				if (i_tx_mode_done)
					state_d = ddr_proto_pkg::st_rnw_bit;
			ddr_proto_pkg::st_rnw_bit:
				if (i_tx_mode_done)
					state_d = ddr_proto_pkg::st_seven_zeros;
			ddr_proto_pkg::st_seven_zeros:
				if (i_tx_mode_done)
					state_d = ddr_proto_pkg::st_address;
			ddr_proto_pkg::st_address:
				if (i_tx_mode_done)
					state_d = ddr_proto_pkg::st_parity;
			ddr_proto_pkg::st_parity:
				if (any_done)
				begin
					if (!data_parity_q)
						state_d = ddr_proto_pkg::st_ack_pre; // command parity done
					else if (rnw)
						state_d = i_rx_error ? ddr_proto_pkg::st_error : ddr_proto_pkg::st_data_pre;
					else
						state_d = i_frmcnt_last ? ddr_proto_pkg::st_crc_pre1 : ddr_proto_pkg::st_data_pre;
				end
			ddr_proto_pkg::st_ack_pre:
				if (i_tx_mode_done)
					state_d = ddr_proto_pkg::st_ack_wait;
			ddr_proto_pkg::st_ack_wait:
				if (i_rx_mode_done) // pre 1 is a nack
					state_d = i_rx_pre ? ddr_proto_pkg::st_error : ddr_proto_pkg::st_first_byte;
			ddr_proto_pkg::st_first_byte:
				if (any_done)
					state_d = i_frmcnt_last ? ddr_proto_pkg::st_zero_pad : ddr_proto_pkg::st_second_byte;
			ddr_proto_pkg::st_second_byte, ddr_proto_pkg::st_zero_pad:
				if (any_done)
					state_d = ddr_proto_pkg::st_parity;
			ddr_proto_pkg::st_data_pre:
				if (any_done)
				begin
					if (!rnw)
						state_d = ddr_proto_pkg::st_abort_bit;
					else if (i_rx_pre) // target has more data
						state_d = ddr_proto_pkg::st_abort_bit;
					else if (!i_frmcnt_last && i_xfer.short_read)
						state_d = ddr_proto_pkg::st_error;
					else
						state_d = ddr_proto_pkg::st_crc_pre2; // target ended the read
				end
			ddr_proto_pkg::st_abort_bit:
				if (any_done)
				begin
					if (!rnw) // target aborts a write by driving 0
						state_d = i_rx_pre ? ddr_proto_pkg::st_first_byte : ddr_proto_pkg::st_error;
					else // controller aborts the read once all bytes are in
						state_d = i_frmcnt_last ? ddr_proto_pkg::st_error : ddr_proto_pkg::st_first_byte;
				end
			ddr_proto_pkg::st_crc_pre1:
				if (any_done)
					state_d = ddr_proto_pkg::st_crc_pre2;
			ddr_proto_pkg::st_crc_pre2:
				if (any_done)
					state_d = (rnw && !i_rx_pre) ? ddr_proto_pkg::st_error : ddr_proto_pkg::st_token;
			ddr_proto_pkg::st_token:
				if (any_done)
					state_d = (rnw && i_rx_error) ? ddr_proto_pkg::st_error : ddr_proto_pkg::st_crc_value;
			ddr_proto_pkg::st_crc_value:
				if (any_done)
					state_d = (rnw && i_rx_error) ? ddr_proto_pkg::st_error : close_st;
			ddr_proto_pkg::st_error:
				if (i_rx_mode_done)
					state_d = close_st;
			ddr_proto_pkg::st_restart, ddr_proto_pkg::st_exit:
				if (i_tx_mode_done)
					state_d = ddr_proto_pkg::st_idle;
			default:
				state_d = ddr_proto_pkg::st_idle;
		endcase
	end

	always_ff @(posedge i_sys_clk or negedge i_sys_rst)
	begin
		if (!i_sys_rst)
		begin
			state_q       <= ddr_proto_pkg::st_idle;
			ack_ready_q   <= 1'b0;
			data_parity_q <= 1'b0;
		end
		else
		begin
			state_q     <= state_d;
			ack_ready_q <= (state_q == ddr_proto_pkg::st_ack_wait) &&
				(state_d == ddr_proto_pkg::st_ack_wait); // high from the 2nd ack cycle
			if (state_q == ddr_proto_pkg::st_idle || state_q == ddr_proto_pkg::st_address)
				data_parity_q <= 1'b0; // command parity comes next
			else if (state_q == ddr_proto_pkg::st_second_byte ||
				state_q == ddr_proto_pkg::st_zero_pad)
				data_parity_q <= 1'b1;
		end
	end

	// error classes follow the branches into st_error
	always_comb
	begin
		o_regf_error_type = ddr_proto_pkg::err_success;
		o_regf_abort      = 1'b0;
		case (state_q)
			ddr_proto_pkg::st_parity:
				if (rnw && data_parity_q && i_rx_mode_done && i_rx_error)
					o_regf_error_type = ddr_proto_pkg::err_parity;
			ddr_proto_pkg::st_ack_wait:
				if (i_rx_mode_done && i_rx_pre)
					o_regf_error_type = ddr_proto_pkg::err_nack;
			ddr_proto_pkg::st_data_pre:
				if (rnw && i_rx_mode_done && !i_rx_pre && !i_frmcnt_last && i_xfer.short_read)
					o_regf_error_type = ddr_proto_pkg::err_short_read;
			ddr_proto_pkg::st_abort_bit:
				if (!rnw && i_rx_mode_done && !i_rx_pre)
				begin
					o_regf_error_type = ddr_proto_pkg::err_bus_aborted;
					o_regf_abort      = 1'b1; // target gave up mid write
				end
				else if (rnw && i_tx_mode_done && i_frmcnt_last)
					o_regf_error_type = ddr_proto_pkg::err_bus_aborted;
			ddr_proto_pkg::st_crc_pre2:
				if (rnw && i_rx_mode_done && !i_rx_pre)
					o_regf_error_type = ddr_proto_pkg::err_frame; // crc preamble read as 00
			ddr_proto_pkg::st_token:
				if (rnw && i_rx_mode_done && i_rx_error)
					o_regf_error_type = ddr_proto_pkg::err_frame;
			ddr_proto_pkg::st_crc_value:
				if (rnw && i_rx_mode_done && i_rx_error)
					o_regf_error_type = ddr_proto_pkg::err_crc;
			default:
				o_regf_error_type = ddr_proto_pkg::err_success;
		endcase
	end

	assign o_status.state       = state_q;
	assign o_status.ack_ready   = ack_ready_q;
	assign o_status.data_parity = data_parity_q;

	a_state_legal: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
		state_q inside {[ddr_proto_pkg::st_idle:ddr_proto_pkg::st_zero_pad]});

	// phy runs one direction at a time, so done pulses never coincide
	a_done_excl: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
		!(i_tx_mode_done && i_rx_mode_done));

endmodule

`default_nettype wire

//--- ddr_lane_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

`include "ddr_macros.svh"

module ddr_lane_ctrl (
	input  wire ddr_proto_pkg::engine_status_t i_status,
	input  wire ddr_regf_pkg::xfer_req_t       i_xfer,
	input  wire                                i_tx_mode_done,
	input  wire                                i_rx_mode_done,
	input  wire                                i_rx_pre,
	input  wire                                i_rx_error,
	input  wire                                i_frmcnt_last,
	input  wire [5:0]                          i_bitcnt,
	output logic                               o_tx_en,
	output ddr_proto_pkg::tx_mode_t            o_tx_mode,
	output logic                               o_rx_en,
	output ddr_proto_pkg::rx_mode_t            o_rx_mode,
	output logic                               o_frmcnt_en,
	output logic                               o_bitcnt_en,
	output logic                               o_bitcnt_rst,
	output logic [7:0]                         o_tx_special_data,
	output logic                               o_sclstall_en,
	output logic [4:0]                         o_sclstall_no_of_cycles
);

	logic       rnw;
	logic [6:0] target_addr;
	logic       stall_bit;    // bit counts where the crc stall goes out
	logic [4:0] close_stall;  // length ahead of the closing pattern

	assign rnw         = i_xfer.rnw;
	assign target_addr = `DDR_ADDR_BASE + {2'b00, i_xfer.dev_index};
	assign stall_bit   = (i_bitcnt == `DDR_STALL_BIT_LO) || (i_bitcnt == `DDR_STALL_BIT_HI);
	assign close_stall = i_xfer.toc ? `DDR_EXIT_STALL : `DDR_RESTART_STALL;

	always_comb
	begin
		o_tx_en                 = 1'b0;
		o_rx_en                 = 1'b0;
		o_tx_mode               = ddr_proto_pkg::tx_special_pre;
		o_rx_mode               = ddr_proto_pkg::rx_preamble;
		o_frmcnt_en             = 1'b1;
		o_bitcnt_en             = 1'b1;
		o_bitcnt_rst            = 1'b0;
		o_tx_special_data       = 8'd0;
		o_sclstall_en           = 1'b0;
		o_sclstall_no_of_cycles = 5'd0;
		case (i_status.state)
			ddr_proto_pkg::st_idle:
			begin
				o_frmcnt_en = 1'b0;
				o_bitcnt_en = 1'b0;
			end
			ddr_proto_pkg::st_cmd_pre:
			begin
				o_tx_en     = 1'b1;
				o_frmcnt_en = 1'b0; // command word is not a data frame
			end
			ddr_proto_pkg::st_rnw_bit:
			begin
				o_tx_en     = 1'b1;
				o_tx_mode   = rnw ? ddr_proto_pkg::tx_one_pre : ddr_proto_pkg::tx_zero_pre;
				o_frmcnt_en = 1'b0;
			end
			ddr_proto_pkg::st_seven_zeros:
			begin
				o_tx_en     = 1'b1;
				o_tx_mode   = ddr_proto_pkg::tx_seven_zeros;
				o_frmcnt_en = 1'b0;
			end
			ddr_proto_pkg::st_address:
			begin
				o_tx_en           = 1'b1;
				o_tx_mode         = ddr_proto_pkg::tx_address;
				o_tx_special_data = {1'b0, target_addr};
			end
			ddr_proto_pkg::st_parity:
				if (rnw && i_status.data_parity)
				begin
					o_rx_en   = 1'b1; // target sends parity of read data
					o_rx_mode = ddr_proto_pkg::rx_parity;
				end
				else
				begin
					o_tx_en   = 1'b1;
					o_tx_mode = ddr_proto_pkg::tx_parity;
				end
			ddr_proto_pkg::st_ack_pre:
			begin
				o_tx_en   = 1'b1;
				o_tx_mode = ddr_proto_pkg::tx_one_pre;
			end
			ddr_proto_pkg::st_ack_wait:
			begin
				o_rx_en      = i_status.ack_ready; // one idle cycle for the bus turnaround
				o_bitcnt_rst = i_rx_mode_done && !i_rx_pre; // ack seen, data starts at bit 0
			end
			ddr_proto_pkg::st_first_byte, ddr_proto_pkg::st_second_byte,
			ddr_proto_pkg::st_zero_pad:
			begin
				o_tx_en   = !rnw;
				o_rx_en   = rnw;
				o_tx_mode = ddr_proto_pkg::tx_byte;
				o_rx_mode = ddr_proto_pkg::rx_byte;
			end
			ddr_proto_pkg::st_data_pre, ddr_proto_pkg::st_crc_pre2:
			begin
				o_tx_en   = !rnw;
				o_rx_en   = rnw;
				o_tx_mode = ddr_proto_pkg::tx_one_pre;
			end
			ddr_proto_pkg::st_abort_bit:
			begin
				o_tx_en   = rnw; // on a read the controller drives the abort bit
				o_rx_en   = !rnw;
				o_tx_mode = i_frmcnt_last ? ddr_proto_pkg::tx_zero_pre : ddr_proto_pkg::tx_one_pre;
			end
			ddr_proto_pkg::st_crc_pre1:
			begin
				o_tx_en   = 1'b1;
				o_tx_mode = ddr_proto_pkg::tx_zero_pre;
			end
			ddr_proto_pkg::st_token:
			begin
				o_tx_en   = !rnw;
				o_rx_en   = rnw;
				o_tx_mode = ddr_proto_pkg::tx_token_crc;
				o_rx_mode = ddr_proto_pkg::rx_token;
			end
			ddr_proto_pkg::st_crc_value:
			begin
				o_tx_en   = !rnw;
				o_rx_en   = rnw;
				o_tx_mode = ddr_proto_pkg::tx_crc_value;
				o_rx_mode = ddr_proto_pkg::rx_crc;
				if (stall_bit && !(rnw && i_rx_error)) // no stall on a bad read crc
				begin
					o_sclstall_en           = 1'b1;
					o_sclstall_no_of_cycles = close_stall;
				end
			end
			ddr_proto_pkg::st_error:
			begin
				o_rx_en      = 1'b1;
				o_rx_mode    = ddr_proto_pkg::rx_error;
				o_bitcnt_rst = 1'b1;
			end
			ddr_proto_pkg::st_restart, ddr_proto_pkg::st_exit:
			begin
				o_tx_en   = 1'b1;
				o_tx_mode = (i_status.state == ddr_proto_pkg::st_exit) ?
					ddr_proto_pkg::tx_exit : ddr_proto_pkg::tx_restart;
				o_sclstall_en           = !i_tx_mode_done; // released with the pattern done
				o_sclstall_no_of_cycles = close_stall;
			end
			default:
				o_bitcnt_en = 1'b0;
		endcase
	end

	// one lane direction at a time
	always_comb
	begin
		a_lane_excl: assert #0 (!(o_tx_en && o_rx_en));
	end

endmodule

`default_nettype wire

//--- ddr_regf_port.sv
`timescale 1ns/1ns
`default_nettype none

`include "ddr_macros.svh"

module ddr_regf_port (
	input  wire                                i_sys_clk,
	input  wire                                i_sys_rst,
	input  wire ddr_proto_pkg::engine_status_t i_status,
	input  wire ddr_regf_pkg::xfer_req_t       i_xfer,
	input  wire                                i_tx_mode_done,
	input  wire                                i_rx_mode_done,
	input  wire                                i_rx_pre,
	input  wire                                i_frmcnt_last,
	output ddr_regf_pkg::regf_port_t           o_regf
);

	logic                    in_data;    // a real data byte is on the bus
	logic                    ack_ok;     // ack done without nack
	logic [`DDR_REGF_AW-1:0] start_addr;
	logic [`DDR_REGF_AW-1:0] addr_q;

	assign in_data = (i_status.state == ddr_proto_pkg::st_first_byte) ||
		(i_status.state == ddr_proto_pkg::st_second_byte);
	assign ack_ok  = (i_status.state == ddr_proto_pkg::st_ack_wait) && i_rx_mode_done && !i_rx_pre;

	// reads start at one fixed block, writes pick immediate or regular
	always_comb
	begin
		if (i_xfer.rnw)
			start_addr = `DDR_RD_ADDR;
		else if (i_xfer.cmd_attr[0])
			start_addr = `DDR_IMM_ADDR;
		else
			start_addr = `DDR_WR_ADDR;
	end

	always_ff @(posedge i_sys_clk or negedge i_sys_rst)
	begin
		if (!i_sys_rst)
			addr_q <= '0;
		else if (ack_ok)
			addr_q <= start_addr;
		else if (in_data && (i_tx_mode_done || i_rx_mode_done))
			addr_q <= i_frmcnt_last ? `DDR_LAST_ADDR : addr_q + 1'b1; // one step per byte
	end

	always_comb
	begin
		o_regf.rd_en = in_data && !i_xfer.rnw; // feeding the serializer
		o_regf.wr_en = in_data && i_xfer.rnw;  // storing deserialized bytes
		o_regf.addr  = addr_q;
	end

	a_regf_excl: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
		!(o_regf.rd_en && o_regf.wr_en));

endmodule

`default_nettype wire

//--- ddr_engine_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "ddr_macros.svh"

module ddr_engine_top (
	input  wire                          i_sys_clk,
	input  wire                          i_sys_rst,
	input  wire                          i_engine_en,
	input  wire                          i_tx_mode_done,
	input  wire                          i_rx_mode_done,
	input  wire                          i_rx_pre,
	input  wire                          i_rx_error,
	input  wire                          i_frmcnt_last,
	input  wire ddr_regf_pkg::xfer_req_t i_xfer,
	input  wire [5:0]                    i_bitcnt,
	output logic                         o_tx_en,
	output ddr_proto_pkg::tx_mode_t      o_tx_mode,
	output logic                         o_rx_en,
	output ddr_proto_pkg::rx_mode_t      o_rx_mode,
	output logic                         o_frmcnt_en,
	output logic                         o_bitcnt_en,
	output logic                         o_bitcnt_rst,
	output logic [7:0]                   o_tx_special_data,
	output logic                         o_sclstall_en,
	output logic [4:0]                   o_sclstall_no_of_cycles,
	output logic                         o_regf_wr_en,
	output logic                         o_regf_rd_en,
	output logic [`DDR_REGF_AW-1:0]      o_regf_addr,
	output logic                         o_regf_abort,
	output ddr_proto_pkg::err_type_t     o_regf_error_type
);

	ddr_proto_pkg::engine_status_t status; // frame state and phase flags
	ddr_regf_pkg::regf_port_t      regf;

	ddr_frame_fsm u_fsm (
		.i_sys_clk         (i_sys_clk),
		.i_sys_rst         (i_sys_rst),
		.i_engine_en       (i_engine_en),
		.i_tx_mode_done    (i_tx_mode_done),
		.i_rx_mode_done    (i_rx_mode_done),
		.i_rx_pre          (i_rx_pre),
		.i_rx_error        (i_rx_error),
		.i_frmcnt_last     (i_frmcnt_last),
		.i_xfer            (i_xfer),
		.o_status          (status),
		.o_regf_error_type (o_regf_error_type),
		.o_regf_abort      (o_regf_abort)
	);

	ddr_lane_ctrl u_lane (
		.i_status                (status),
		.i_xfer                  (i_xfer),
		.i_tx_mode_done          (i_tx_mode_done),
		.i_rx_mode_done          (i_rx_mode_done),
		.i_rx_pre                (i_rx_pre),
		.i_rx_error              (i_rx_error),
		.i_frmcnt_last           (i_frmcnt_last),
		.i_bitcnt                (i_bitcnt),
		.o_tx_en                 (o_tx_en),
		.o_tx_mode               (o_tx_mode),
		.o_rx_en                 (o_rx_en),
		.o_rx_mode               (o_rx_mode),
		.o_frmcnt_en             (o_frmcnt_en),
		.o_bitcnt_en             (o_bitcnt_en),
		.o_bitcnt_rst            (o_bitcnt_rst),
		.o_tx_special_data       (o_tx_special_data),
		.o_sclstall_en           (o_sclstall_en),
		.o_sclstall_no_of_cycles (o_sclstall_no_of_cycles)
	);

	ddr_regf_port u_regf (
		.i_sys_clk      (i_sys_clk),
		.i_sys_rst      (i_sys_rst),
		.i_status       (status),
		.i_xfer         (i_xfer),
		.i_tx_mode_done (i_tx_mode_done),
		.i_rx_mode_done (i_rx_mode_done),
		.i_rx_pre       (i_rx_pre),
		.i_frmcnt_last  (i_frmcnt_last),
		.o_regf         (regf)
	);

	// flat register file pins
	assign o_regf_wr_en = regf.wr_en;
	assign o_regf_rd_en = regf.rd_en;
	assign o_regf_addr  = regf.addr;

endmodule

`default_nettype wire

//--- tb_ddr_tasks.svh
`ifndef TB_DDR_TASKS_SVH
`define TB_DDR_TASKS_SVH

// x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
	return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

// one lfsr step per bit taken
task automatic draw_bits(input int n, output logic [7:0] v);
	v = '0;
	for (int k = 0; k < n; k++)
	begin
		lfsr_q = lfsr_next(lfsr_q);
		v      = {v[6:0], lfsr_q[0]};
	end
endtask

task automatic tx_mode_is(input ddr_proto_pkg::tx_mode_t exp);
	if (o_tx_mode !== exp)
		abort_run($sformatf("Error: o_tx_mode got 0x%h expected 0x%h", o_tx_mode, exp));
endtask

task automatic rx_mode_is(input ddr_proto_pkg::rx_mode_t exp);
	if (o_rx_mode !== exp)
		abort_run($sformatf("Error: o_rx_mode got 0x%h expected 0x%h", o_rx_mode, exp));
endtask

task automatic err_type_is(input ddr_proto_pkg::err_type_t exp);
	if (o_regf_error_type !== exp)
		abort_run($sformatf("Error: o_regf_error_type got 0x%h expected 0x%h",
			o_regf_error_type, exp));
endtask

task automatic regf_addr_is(input logic [`DDR_REGF_AW-1:0] exp);
	if (o_regf_addr !== exp)
		abort_run($sformatf("Error: o_regf_addr got 0x%h expected 0x%h", o_regf_addr, exp));
endtask

task automatic flag_is(input string name, input logic got, input logic exp);
	if (got !== exp)
		abort_run($sformatf("Error: %s got 0x%h expected 0x%h", name, got, exp));
endtask

task automatic count_is(input string name, input logic [7:0] got, input logic [7:0] exp);
	if (got !== exp)
		abort_run($sformatf("Error: %s got 0x%h expected 0x%h", name, got, exp));
endtask

// device index and dtt come from the lfsr while the test fixes the rest
task automatic random_xfer(input logic toc, input logic short_rd, input logic rnw,
	input logic [2:0] attr, output ddr_regf_pkg::xfer_req_t x);
	logic [7:0] dev;
	logic [7:0] cnt;
	draw_bits(5, dev);
	draw_bits(3, cnt);
	x.toc        = toc;
	x.dev_index  = dev[4:0];
	x.short_read = short_rd;
	x.rnw        = rnw;
	x.cmd_attr   = attr;
	x.dtt        = cnt[2:0];
endtask

task automatic wait_lane_enable();
	@(negedge i_sys_clk);
	while (!(o_tx_en || o_rx_en)) // ack turnaround has a gap
		@(negedge i_sys_clk);
endtask

// phy answer of one done pulse with its levels
task automatic pulse_done(input logic use_tx, input logic pre, input logic err,
	input logic last, input ddr_proto_pkg::err_type_t exp_err);
	@(posedge i_sys_clk);
	i_tx_mode_done <= use_tx;
	i_rx_mode_done <= !use_tx;
	i_rx_pre       <= pre;
	i_rx_error     <= err;
	i_frmcnt_last  <= last;
	@(negedge i_sys_clk);
	err_type_is(exp_err); // error type is valid with the pulse
	seen_stall_en = o_sclstall_en;
	@(posedge i_sys_clk);
	i_tx_mode_done <= 1'b0;
	i_rx_mode_done <= 1'b0;
	i_rx_pre       <= 1'b0;
	i_rx_error     <= 1'b0;
	i_frmcnt_last  <= 1'b0;
endtask

task automatic tx_step(input ddr_proto_pkg::tx_mode_t m, input logic last);
	wait_lane_enable();
	flag_is("o_tx_en", o_tx_en, 1'b1);
	tx_mode_is(m);
	pulse_done(1'b1, 1'b0, 1'b0, last, ddr_proto_pkg::err_success);
endtask

task automatic rx_step(input ddr_proto_pkg::rx_mode_t m, input logic pre, input logic err,
	input logic last, input ddr_proto_pkg::err_type_t exp_err);
	wait_lane_enable();
	flag_is("o_rx_en", o_rx_en, 1'b1);
	rx_mode_is(m);
	pulse_done(1'b0, pre, err, last, exp_err);
endtask

// data byte where a read enables the regf write and a write the regf read
task automatic byte_step(input logic rd, input logic [`DDR_REGF_AW-1:0] exp_addr,
	input logic last);
	wait_lane_enable();
	regf_addr_is(exp_addr);
	flag_is("o_regf_rd_en", o_regf_rd_en, !rd);
	flag_is("o_regf_wr_en", o_regf_wr_en, rd);
	flag_is("o_frmcnt_en", o_frmcnt_en, 1'b1); // data frames are counted
	flag_is("o_bitcnt_rst", o_bitcnt_rst, 1'b0);
	if (rd)
		rx_mode_is(ddr_proto_pkg::rx_byte);
	else
		tx_mode_is(ddr_proto_pkg::tx_byte);
	pulse_done(!rd, 1'b0, 1'b0, last, ddr_proto_pkg::err_success);
endtask

// command word up to the ack wait
task automatic send_command(input ddr_regf_pkg::xfer_req_t x);
	@(posedge i_sys_clk);
	i_xfer      <= x;
	i_engine_en <= 1'b1;
	@(posedge i_sys_clk);
	i_engine_en <= 1'b0;
	@(negedge i_sys_clk);
	flag_is("o_frmcnt_en", o_frmcnt_en, 1'b0); // command word is no data frame
	tx_step(ddr_proto_pkg::tx_special_pre, 1'b0);
	tx_step(x.rnw ? ddr_proto_pkg::tx_one_pre : ddr_proto_pkg::tx_zero_pre, 1'b0);
	tx_step(ddr_proto_pkg::tx_seven_zeros, 1'b0);
	@(negedge i_sys_clk);
	count_is("o_tx_special_data", o_tx_special_data, {3'b000, x.dev_index} + 8'd8);
	tx_step(ddr_proto_pkg::tx_address, 1'b0);
	tx_step(ddr_proto_pkg::tx_parity, 1'b0);
	tx_step(ddr_proto_pkg::tx_one_pre, 1'b0);
	@(negedge i_sys_clk);
	flag_is("o_rx_en", o_rx_en, 1'b0); // first ack cycle idles
endtask

// error state drains before the restart or exit
task automatic close_frame(input logic toc);
	wait_lane_enable();
	flag_is("o_bitcnt_rst", o_bitcnt_rst, 1'b1); // bit count held at 0 in the error state
	rx_step(ddr_proto_pkg::rx_error, 1'b0, 1'b0, 1'b0, ddr_proto_pkg::err_success);
	tx_step(toc ? ddr_proto_pkg::tx_exit : ddr_proto_pkg::tx_restart, 1'b0);
endtask

task automatic nack_close(input logic toc);
	rx_step(ddr_proto_pkg::rx_preamble, 1'b1, 1'b0, 1'b0, ddr_proto_pkg::err_nack);
	close_frame(toc);
endtask

task automatic idle_outputs_ok();
	@(negedge i_sys_clk);
	flag_is("o_tx_en", o_tx_en, 1'b0);
	flag_is("o_rx_en", o_rx_en, 1'b0);
	flag_is("o_bitcnt_en", o_bitcnt_en, 1'b0); // only idle clears it
	flag_is("o_frmcnt_en", o_frmcnt_en, 1'b0);
	flag_is("o_sclstall_en", o_sclstall_en, 1'b0);
	flag_is("o_regf_abort", o_regf_abort, 1'b0);
	tx_mode_is(ddr_proto_pkg::tx_special_pre);
	rx_mode_is(ddr_proto_pkg::rx_preamble);
	err_type_is(ddr_proto_pkg::err_success);
endtask

// two words where the target lets the write go on after the first
task automatic write_imm_exit_frame();
	ddr_regf_pkg::xfer_req_t x;
	random_xfer(1'b1, 1'b0, 1'b0, 3'b001, x);
	send_command(x);
	rx_step(ddr_proto_pkg::rx_preamble, 1'b0, 1'b0, 1'b0, ddr_proto_pkg::err_success);
	byte_step(1'b0, 12'd20, 1'b0);
	byte_step(1'b0, 12'd21, 1'b0);
	tx_step(ddr_proto_pkg::tx_parity, 1'b0);
	tx_step(ddr_proto_pkg::tx_one_pre, 1'b0); // data preamble
	rx_step(ddr_proto_pkg::rx_preamble, 1'b1, 1'b0, 1'b0, ddr_proto_pkg::err_success);
	byte_step(1'b0, 12'd22, 1'b0);
	byte_step(1'b0, 12'd23, 1'b1);
	@(negedge i_sys_clk);
	regf_addr_is(12'd1000); // parked after the last byte
	tx_step(ddr_proto_pkg::tx_parity, 1'b1);
	tx_step(ddr_proto_pkg::tx_zero_pre, 1'b0);
	tx_step(ddr_proto_pkg::tx_one_pre, 1'b0);
	tx_step(ddr_proto_pkg::tx_token_crc, 1'b0);
	tx_step(ddr_proto_pkg::tx_crc_value, 1'b0);
	tx_step(ddr_proto_pkg::tx_exit, 1'b0);
	idle_outputs_ok();
endtask

task automatic address_byte_sweep();
	ddr_regf_pkg::xfer_req_t x;
	for (int n = 0; n < 3; n++)
	begin
		random_xfer(1'b1, 1'b0, 1'b1, 3'b000, x);
		send_command(x); // address byte checked in here
		nack_close(1'b1);
	end
endtask

task automatic nack_restart_frame();
	ddr_regf_pkg::xfer_req_t x;
	random_xfer(1'b0, 1'b0, 1'b0, 3'b001, x);
	send_command(x);
	nack_close(1'b0);
	idle_outputs_ok();
endtask

task automatic read_parity_error_frame();
	ddr_regf_pkg::xfer_req_t x;
	random_xfer(1'b0, 1'b0, 1'b1, 3'b000, x);
	send_command(x);
	rx_step(ddr_proto_pkg::rx_preamble, 1'b0, 1'b0, 1'b0, ddr_proto_pkg::err_success);
	byte_step(1'b1, 12'd10, 1'b0);
	byte_step(1'b1, 12'd11, 1'b0);
	rx_step(ddr_proto_pkg::rx_parity, 1'b0, 1'b1, 1'b0, ddr_proto_pkg::err_parity);
	close_frame(1'b0);
endtask

task automatic crc_stall_lengths();
	ddr_regf_pkg::xfer_req_t x;
	logic [7:0] stall_len;
	for (int t = 1; t >= 0; t--)
	begin
		random_xfer(t[0], 1'b0, 1'b0, 3'b000, x);
		stall_len = t[0] ? 8'd16 : 8'd10; // exit stalls longer
		send_command(x);
		rx_step(ddr_proto_pkg::rx_preamble, 1'b0, 1'b0, 1'b0, ddr_proto_pkg::err_success);
		byte_step(1'b0, 12'd1, 1'b0);
		byte_step(1'b0, 12'd2, 1'b1);
		tx_step(ddr_proto_pkg::tx_parity, 1'b1);
		tx_step(ddr_proto_pkg::tx_zero_pre, 1'b0);
		tx_step(ddr_proto_pkg::tx_one_pre, 1'b0);
		tx_step(ddr_proto_pkg::tx_token_crc, 1'b0);
		@(negedge i_sys_clk);
		flag_is("o_sclstall_en", o_sclstall_en, 1'b0); // bit count still 0
		@(posedge i_sys_clk);
		i_bitcnt <= 6'd11;
		@(negedge i_sys_clk);
		flag_is("o_sclstall_en", o_sclstall_en, 1'b1);
		count_is("o_sclstall_no_of_cycles", {3'b000, o_sclstall_no_of_cycles}, stall_len);
		@(posedge i_sys_clk);
		i_bitcnt <= 6'd0;
		tx_step(ddr_proto_pkg::tx_crc_value, 1'b0);
		wait_lane_enable();
		tx_mode_is(t[0] ? ddr_proto_pkg::tx_exit : ddr_proto_pkg::tx_restart);
		flag_is("o_sclstall_en", o_sclstall_en, 1'b1);
		count_is("o_sclstall_no_of_cycles", {3'b000, o_sclstall_no_of_cycles}, stall_len);
		pulse_done(1'b1, 1'b0, 1'b0, 1'b0, ddr_proto_pkg::err_success);
		flag_is("o_sclstall_en", seen_stall_en, 1'b0); // dropped with the done pulse
	end
endtask

// target ends early while short reads are errors
task automatic short_read_error_frame();
	ddr_regf_pkg::xfer_req_t x;
	random_xfer(1'b1, 1'b1, 1'b1, 3'b000, x);
	send_command(x);
	rx_step(ddr_proto_pkg::rx_preamble, 1'b0, 1'b0, 1'b0, ddr_proto_pkg::err_success);
	byte_step(1'b1, 12'd10, 1'b0);
	byte_step(1'b1, 12'd11, 1'b0);
	rx_step(ddr_proto_pkg::rx_parity, 1'b0, 1'b0, 1'b0, ddr_proto_pkg::err_success);
	rx_step(ddr_proto_pkg::rx_preamble, 1'b0, 1'b0, 1'b0, ddr_proto_pkg::err_short_read);
	close_frame(1'b1);
endtask

`endif

//--- tb_ddr_engine.sv
`timescale 1ns/1ns
`default_nettype none

`include "ddr_macros.svh"

module tb_ddr_engine;

	localparam int clk_period      = 4;
	localparam int n_tests         = 6;
	localparam int cycles_per_test = 200;

	logic                          i_sys_clk;
	logic                          i_sys_rst;
	logic                          i_engine_en;
	logic                          i_tx_mode_done;
	logic                          i_rx_mode_done;
	logic                          i_rx_pre;
	logic                          i_rx_error;
	logic                          i_frmcnt_last;
	ddr_regf_pkg::xfer_req_t       i_xfer;
	logic [5:0]                    i_bitcnt;
	logic                          o_tx_en;
	ddr_proto_pkg::tx_mode_t       o_tx_mode;
	logic                          o_rx_en;
	ddr_proto_pkg::rx_mode_t       o_rx_mode;
	logic                          o_frmcnt_en;
	logic                          o_bitcnt_en;
	logic                          o_bitcnt_rst;
	logic [7:0]                    o_tx_special_data;
	logic                          o_sclstall_en;
	logic [4:0]                    o_sclstall_no_of_cycles;
	logic                          o_regf_wr_en;
	logic                          o_regf_rd_en;
	logic [`DDR_REGF_AW-1:0]       o_regf_addr;
	logic                          o_regf_abort;
	ddr_proto_pkg::err_type_t      o_regf_error_type;

	logic [15:0] lfsr_q;        // picks device index and dtt
	logic        seen_stall_en; // stall enable while the last done was high

	ddr_engine_top i_dut (
		.i_sys_clk               (i_sys_clk),
		.i_sys_rst               (i_sys_rst),
		.i_engine_en             (i_engine_en),
		.i_tx_mode_done          (i_tx_mode_done),
		.i_rx_mode_done          (i_rx_mode_done),
		.i_rx_pre                (i_rx_pre),
		.i_rx_error              (i_rx_error),
		.i_frmcnt_last           (i_frmcnt_last),
		.i_xfer                  (i_xfer),
		.i_bitcnt                (i_bitcnt),
		.o_tx_en                 (o_tx_en),
		.o_tx_mode               (o_tx_mode),
		.o_rx_en                 (o_rx_en),
		.o_rx_mode               (o_rx_mode),
		.o_frmcnt_en             (o_frmcnt_en),
		.o_bitcnt_en             (o_bitcnt_en),
		.o_bitcnt_rst            (o_bitcnt_rst),
		.o_tx_special_data       (o_tx_special_data),
		.o_sclstall_en           (o_sclstall_en),
		.o_sclstall_no_of_cycles (o_sclstall_no_of_cycles),
		.o_regf_wr_en            (o_regf_wr_en),
		.o_regf_rd_en            (o_regf_rd_en),
		.o_regf_addr             (o_regf_addr),
		.o_regf_abort            (o_regf_abort),
		.o_regf_error_type       (o_regf_error_type)
	);

	initial
	begin
		i_sys_clk = 1'b0;
		forever #(clk_period / 2) i_sys_clk = ~i_sys_clk;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("sim failed");
		$fatal(1, "run stopped");
	endtask

	`include "tb_ddr_tasks.svh"

	// budget grows with the number of tests
	initial
	begin
		#(n_tests * cycles_per_test * clk_period);
		abort_run("watchdog expired, the engine stopped asking for done pulses");
	end

	initial
	begin
		i_sys_rst      = 1'b0;
		i_engine_en    = 1'b0;
		i_tx_mode_done = 1'b0;
		i_rx_mode_done = 1'b0;
		i_rx_pre       = 1'b0;
		i_rx_error     = 1'b0;
		i_frmcnt_last  = 1'b0;
		i_xfer         = '0;
		i_bitcnt       = '0;
		lfsr_q         = 16'd58977;
		seen_stall_en  = 1'b0;
		repeat (4) @(posedge i_sys_clk);
		i_sys_rst <= 1'b1;
		idle_outputs_ok(); // reset values
		write_imm_exit_frame();
		address_byte_sweep();
		nack_restart_frame();
		read_parity_error_frame();
		crc_stall_lengths();
		short_read_error_frame();
		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
+incdir+.
ddr_proto_pkg.sv
ddr_regf_pkg.sv
ddr_frame_fsm.sv
ddr_lane_ctrl.sv
ddr_regf_port.sv
ddr_engine_top.sv
tb_ddr_engine.sv

//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_ddr_engine \
		-f files.f -Mdir obj_dir -o tb_ddr_engine

run: compile
	./obj_dir/tb_ddr_engine | tee sim.log
	grep -q "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log
